/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // bus and address widths
  localparam int data_w      = 16;  // data bus and register width
  localparam int log_addr_w  = 9;   // 8 logical pages
  localparam int phys_addr_w = 10;  // 16 physical pages
  localparam int page_off_w  = 6;   // 64 words per page

  localparam int log_page_w  = log_addr_w - page_off_w;   // 3 bits
  localparam int phys_page_w = phys_addr_w - page_off_w;  // 4 bits

  localparam int reg_idx_w   = 4;   // 16 registers
  localparam int op_w        = 8;   // opcode field in the high word

  // opcodes, anything else runs as a no-op
  localparam logic [op_w-1:0] op_jmp       = 8'd1;
  localparam logic [op_w-1:0] op_ram2reg   = 8'd2;
  localparam logic [op_w-1:0] op_reg2ram   = 8'd3;
  localparam logic [op_w-1:0] op_num2reg   = 8'd4;
  localparam logic [op_w-1:0] op_reg_plus  = 8'd5;
  localparam logic [op_w-1:0] op_reg_minus = 8'd6;

  // every memory access is a translate phase followed by a bus phase
  typedef enum logic [3:0] {
    fetch_hi_xlat,
    fetch_hi_bus,
    fetch_lo_xlat,
    fetch_lo_bus,
    decode,
    load_xlat,
    load_bus,
    store_xlat,
    store_bus
  } core_state_t;

endpackage

`default_nettype wire

/* verilog/page_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

module page_mmu (
  input  logic                            clka,
  input  logic                            rst,
  input  logic                            xlat_req,
  input  logic [cpu_pkg::log_addr_w-1:0]  xlat_addr,
  output logic                            xlat_done,
  output logic [cpu_pkg::phys_addr_w-1:0] phys_addr
);

  import cpu_pkg::*;

  // page table, one entry per logical page
  logic                   pt_valid [2**log_page_w];
  logic [phys_page_w-1:0] pt_page  [2**log_page_w];
  logic [phys_page_w-1:0] next_free;  // next unallocated physical page

  logic [log_page_w-1:0]  req_page;
  logic [page_off_w-1:0]  req_off;
  logic                   req_hit;

  logic                   miss_wait;  // entry written, address formed next cycle
  logic [log_page_w-1:0]  hold_page;
  logic [page_off_w-1:0]  hold_off;

  // page size is a power of two so the split is plain bit selection
  assign req_page = xlat_addr[log_addr_w-1 -: log_page_w];
  assign req_off  = xlat_addr[page_off_w-1:0];
  assign req_hit  = pt_valid[req_page];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < 2**log_page_w; i++) begin
        pt_valid[i] <= 1'b0;
        pt_page[i]  <= '0;
      end
      pt_valid[0] <= 1'b1;  // logical page 0 sits in physical page 0
      next_free   <= phys_page_w'(1);
      miss_wait   <= 1'b0;
      xlat_done   <= 1'b0;
    end else begin
      xlat_done <= 1'b0;
      if (miss_wait) begin
        miss_wait <= 1'b0;
        xlat_done <= 1'b1;
      end else if (xlat_req) begin
        if (req_hit) begin
          xlat_done <= 1'b1;
        end else begin
          // first touch of this page, allocate
          pt_valid[req_page] <= 1'b1;
          pt_page[req_page]  <= next_free;
          next_free          <= next_free + 1'b1;
          miss_wait          <= 1'b1;
        end
      end
    end
  end

  // translated address and the held request
  always_ff @(posedge clka) begin
    if (xlat_req && !miss_wait) begin
      hold_page <= req_page;
      hold_off  <= req_off;
    end
    if (miss_wait) begin
      phys_addr <= {pt_page[hold_page], hold_off};
    end else if (xlat_req && req_hit) begin
      phys_addr <= {pt_page[req_page], req_off};
    end
  end

  // done answers a request from one cycle (hit) or two cycles (miss) back
  a_done_has_req: assert property (@(posedge clka) disable iff (!rst)
    xlat_done |-> $past(xlat_req, 1) || $past(xlat_req, 2));

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic                            clka,
  input  logic                            rst,
  output logic                            xlat_req,
  output logic [cpu_pkg::log_addr_w-1:0]  xlat_addr,
  input  logic                            xlat_done,
  input  logic [cpu_pkg::phys_addr_w-1:0] phys_addr,
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic                            wb_we,
  output logic [cpu_pkg::phys_addr_w-1:0] wb_adr,
  output logic [cpu_pkg::data_w-1:0]      wb_dat_w,
  input  logic [cpu_pkg::data_w-1:0]      wb_dat_r,
  input  logic                            wb_ack
);

  import cpu_pkg::*;

  core_state_t           state;

  logic [data_w-1:0]     regs [2**reg_idx_w];
  logic [log_addr_w-1:0] pc;
  logic [op_w-1:0]       inst_op;       // from the high word
  logic [reg_idx_w-1:0]  inst_reg;      // low bits of the register byte
  logic [data_w-1:0]     inst_operand;  // second word

  logic                  req_sent;   // request out, waiting for done
  logic                  in_xlat;
  logic [log_addr_w-1:0] log_addr;   // address to translate in this state
  core_state_t           bus_state;  // bus phase after the translation
  logic                  xlat_issue;
  logic                  xlat_accept;
  logic                  hi_take;
  logic                  lo_take;

  always_comb begin
    in_xlat   = 1'b0;
    log_addr  = inst_operand[log_addr_w-1:0];  // data address for load/store
    bus_state = state;
    case (state)
      fetch_hi_xlat: begin
        in_xlat   = 1'b1;
        log_addr  = pc;
        bus_state = fetch_hi_bus;
      end
      fetch_lo_xlat: begin
        in_xlat   = 1'b1;
        log_addr  = pc;
        bus_state = fetch_lo_bus;
      end
      load_xlat: begin
        in_xlat   = 1'b1;
        bus_state = load_bus;
      end
      store_xlat: begin
        in_xlat   = 1'b1;
        bus_state = store_bus;
      end
      default: ;
    endcase
  end

  assign xlat_issue  = in_xlat && !req_sent;
  assign xlat_accept = in_xlat && req_sent && xlat_done;
  assign hi_take     = (state == fetch_hi_bus) && wb_ack;
  assign lo_take     = (state == fetch_lo_bus) && wb_ack;

  // control path, pc and register file
  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= fetch_hi_xlat;
      req_sent <= 1'b0;
      xlat_req <= 1'b0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      pc       <= '0;
      for (int i = 0; i < 2**reg_idx_w; i++) begin
        regs[i] <= '0;
      end
    end else begin
      xlat_req <= xlat_issue;  // single cycle pulse
      if (xlat_issue) begin
        req_sent <= 1'b1;
      end
      if (xlat_accept) begin
        req_sent <= 1'b0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= (state == store_xlat);
        state    <= bus_state;
      end
      if (wb_stb && wb_ack) begin
        wb_cyc <= 1'b0;  // drop in the cycle after ack
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
      end

      case (state)
        fetch_hi_bus: if (wb_ack) begin
          pc    <= pc + 1'b1;
          state <= fetch_lo_xlat;
        end
        fetch_lo_bus: if (wb_ack) begin
          pc    <= pc + 1'b1;
          state <= decode;
        end
        decode: begin
          state <= fetch_hi_xlat;
          case (inst_op)
            op_jmp:       pc <= inst_operand[log_addr_w-1:0];
            op_ram2reg:   state <= load_xlat;
            op_reg2ram:   state <= store_xlat;
            op_num2reg:   regs[inst_reg] <= inst_operand;
            op_reg_plus:  regs[inst_reg] <= regs[inst_reg] + inst_operand;
            op_reg_minus: regs[inst_reg] <= regs[inst_reg] - inst_operand;
            default: ;  // unused opcode, just move on
          endcase
        end
        load_bus: if (wb_ack) begin
          regs[inst_reg] <= wb_dat_r;
          state          <= fetch_hi_xlat;
        end
        store_bus: if (wb_ack) begin
          state <= fetch_hi_xlat;
        end
        default: ;
      endcase
    end
  end

  // address and data registers, instruction fields
  always_ff @(posedge clka) begin
    if (xlat_issue) begin
      xlat_addr <= log_addr;
    end
    if (xlat_accept) begin
      wb_adr   <= phys_addr;
      wb_dat_w <= regs[inst_reg];  // only meaningful for a store
    end
    if (hi_take) begin
      inst_op  <= wb_dat_r[data_w-1 -: op_w];
      inst_reg <= wb_dat_r[reg_idx_w-1:0];
    end
    if (lo_take) begin
      inst_operand <= wb_dat_r;
    end
  end

  a_stb_in_cyc: assert property (@(posedge clka) disable iff (!rst)
    wb_stb |-> wb_cyc);

  // master holds the request steady until the slave acks
  a_req_stable: assert property (@(posedge clka) disable iff (!rst)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));

endmodule

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic                            clka,
  input  logic                            rst,
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic                            wb_we,
  output logic [cpu_pkg::phys_addr_w-1:0] wb_adr,
  output logic [cpu_pkg::data_w-1:0]      wb_dat_w,
  input  logic [cpu_pkg::data_w-1:0]      wb_dat_r,
  input  logic                            wb_ack
);

  import cpu_pkg::*;

  logic                   xlat_req;   // core to mmu
  logic [log_addr_w-1:0]  xlat_addr;
  logic                   xlat_done;  // mmu to core
  logic [phys_addr_w-1:0] phys_addr;

  cpu_core u_core (
    .clka      (clka),
    .rst       (rst),
    .xlat_req  (xlat_req),
    .xlat_addr (xlat_addr),
    .xlat_done (xlat_done),
    .phys_addr (phys_addr),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

  page_mmu u_mmu (
    .clka      (clka),
    .rst       (rst),
    .xlat_req  (xlat_req),
    .xlat_addr (xlat_addr),
    .xlat_done (xlat_done),
    .phys_addr (phys_addr)
  );

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  localparam int num_tests   = 12;
  localparam int cycle_limit = num_tests * 40 * 3 * 6;
  localparam logic [7:0] jmp_code     = 8'd1;  // ISA opcode values
  localparam logic [7:0] ram2reg_code = 8'd2;
  localparam logic [7:0] reg2ram_code = 8'd3;
  localparam logic [7:0] num2reg_code = 8'd4;
  localparam logic [7:0] plus_code    = 8'd5;
  localparam logic [7:0] minus_code   = 8'd6;

  logic        clka = 1'b0;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [9:0]  wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;

  integer      seed;
  logic [15:0] mem [1024];        // memory seen by the DUT
  logic [15:0] model_mem [1024];  // reference copy
  logic [15:0] m_regs [16];
  logic [8:0]  m_pc;
  logic        m_valid [8];
  logic [3:0]  m_page [8];
  logic [3:0]  m_next_free;
  logic        m_done;            // final self jump reached
  int          m_insts;
  logic [9:0]  exp_adr [$];       // predicted transactions in order
  logic        exp_we [$];
  logic [15:0] exp_dat [$];
  int          ack_wait;
  logic        drop_due;          // cyc and stb must be low on the next edge
  int          cycles = 0;
  int          errors = 0;
  int          test_errs;
  int          accesses;
  int          failed = 0;

  cpu_top DUT (
    .clka     (clka),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #5 clka = ~clka;

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    if (exp !== got) begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
      test_errs++;
    end
  endtask

  // page table walk with allocation on first touch
  function automatic logic [9:0] translate(input logic [8:0] la);
    logic [2:0] lp;
    lp = la[8:6];
    if (!m_valid[lp]) begin
      m_valid[lp] = 1'b1;
      m_page[lp]  = m_next_free;
      m_next_free = m_next_free + 4'd1;
    end
    return {m_page[lp], la[5:0]};
  endfunction

  task automatic expect_access(input logic [9:0] adr, input logic we, input logic [15:0] dat);
    exp_adr.push_back(adr);
    exp_we.push_back(we);
    exp_dat.push_back(dat);
  endtask

  // runs one instruction of the ISA and queues its bus accesses
  task automatic model_step;
    logic [9:0]  pa;
    logic [15:0] hi;
    logic [15:0] lo;
    logic [8:0]  start;
    logic [3:0]  r;
    start = m_pc;
    pa = translate(m_pc);
    expect_access(pa, 1'b0, 16'h0);
    hi   = model_mem[pa];
    m_pc = m_pc + 9'd1;
    pa = translate(m_pc);
    expect_access(pa, 1'b0, 16'h0);
    lo   = model_mem[pa];
    m_pc = m_pc + 9'd1;
    r = hi[3:0];
    m_insts++;
    case (hi[15:8])
      jmp_code: begin
        if (lo[8:0] == start) m_done = 1'b1;
        m_pc = lo[8:0];
      end
      ram2reg_code: begin
        pa = translate(lo[8:0]);
        expect_access(pa, 1'b0, 16'h0);
        m_regs[r] = model_mem[pa];
      end
      reg2ram_code: begin
        pa = translate(lo[8:0]);
        expect_access(pa, 1'b1, m_regs[r]);
        model_mem[pa] = m_regs[r];
      end
      num2reg_code: m_regs[r] = lo;
      plus_code:    m_regs[r] = m_regs[r] + lo;   // wraps at 16 bits
      minus_code:   m_regs[r] = m_regs[r] - lo;
      default: ;
    endcase
  endtask

  task automatic reset_model;
    for (int i = 0; i < 16; i++) m_regs[i] = 16'h0;
    for (int i = 0; i < 8; i++) begin
      m_valid[i] = 1'b0;
      m_page[i]  = 4'h0;
    end
    m_valid[0]  = 1'b1;
    m_next_free = 4'd1;
    m_pc        = 9'd0;
    m_done      = 1'b0;
    m_insts     = 0;
    exp_adr.delete();
    exp_we.delete();
    exp_dat.delete();
  endtask

  // random program in physical page 0, random data elsewhere
  task automatic gen_program;
    int          n;
    int          k;
    int          t;
    logic [7:0]  op;
    logic [15:0] hi;
    logic [15:0] lo;
    for (int a = 0; a < 1024; a++) begin
      mem[a]       = 16'($random(seed));
      model_mem[a] = mem[a];
    end
    n = 1 + $unsigned($random(seed)) % 31;
    for (int i = 0; i < n; i++) begin
      k = $unsigned($random(seed)) % 7;
      if (k == 6) op = 8'd7 + 8'($unsigned($random(seed)) % 249);  // unused opcode
      else op = 8'(k + 1);
      hi = {op, 4'($random(seed)), 2'b00, 2'($random(seed))};  // junk above reg bits
      lo = 16'($random(seed));
      if (op == jmp_code) begin
        t  = i + 1 + $unsigned($random(seed)) % (n - i);  // forward only
        lo = {lo[15:9], 9'(2 * t)};
      end else if (op == reg2ram_code) begin
        lo[8:6] = 3'(1 + $unsigned($random(seed)) % 7);  // keep code page intact
      end
      mem[2*i]       = hi;
      mem[2*i+1]     = lo;
      model_mem[2*i] = hi;
      model_mem[2*i+1] = lo;
    end
    mem[2*n]         = {jmp_code, 8'h00};  // jump to itself
    mem[2*n+1]       = 16'(2 * n);
    model_mem[2*n]   = mem[2*n];
    model_mem[2*n+1] = mem[2*n+1];
  endtask

  task automatic observe_access;
    logic [9:0]  adr;
    logic        we;
    logic [15:0] dat;
    if (exp_adr.size() == 0 && !m_done) model_step();
    if (exp_adr.size() == 0) return;  // idle loop on the final jump
    adr = exp_adr.pop_front();
    we  = exp_we.pop_front();
    dat = exp_dat.pop_front();
    compare_value("wb_cyc", 32'd1, 32'(wb_cyc));
    compare_value("wb_adr", 32'(adr), 32'(wb_adr));
    compare_value("wb_we", 32'(we), 32'(wb_we));
    if (we) compare_value("wb_dat_w", 32'(dat), 32'(wb_dat_w));
    accesses++;
  endtask

  // Wishbone slave, ack after 1 to 4 cycles for exactly one cycle
  always @(posedge clka) begin
    if (!rst) begin
      wb_ack   <= 1'b0;
      ack_wait = -1;
      drop_due = 1'b0;
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;  // strobe falls on this edge
      ack_wait = -1;
      drop_due = 1'b1;
    end else begin
      if (drop_due) begin
        compare_value("wb_cyc", 32'd0, 32'(wb_cyc));  // released after the ack
        compare_value("wb_stb", 32'd0, 32'(wb_stb));
        drop_due = 1'b0;
      end
      if (wb_stb) begin
        if (ack_wait < 0) ack_wait = $unsigned($random(seed)) % 4;
        if (ack_wait == 0) begin
          observe_access();
          if (wb_we) mem[wb_adr] = wb_dat_w;
          else wb_dat_r <= mem[wb_adr];
          wb_ack   <= 1'b1;
          ack_wait = -1;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
    end
  end

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a program never reached its final jump", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    seed = 32'hb9f89028;
    rst      <= 1'b0;
    wb_ack   <= 1'b0;
    wb_dat_r <= 16'h0;
    for (int t = 0; t < num_tests; t++) begin
      @(posedge clka);
      rst <= 1'b0;
      @(posedge clka);
      gen_program();
      reset_model();
      test_errs = 0;
      accesses  = 0;
      @(posedge clka);
      rst <= 1'b1;
      while (!(m_done && exp_adr.size() == 0)) @(negedge clka);
      $display("test %0d: %0d instructions, %0d accesses, %0d mismatches",
               t, m_insts, accesses, test_errs);
      if (test_errs != 0) failed++;
    end
    $display("tests %0d, failed %0d, mismatches %0d", num_tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/cpu_pkg.sv
verilog/page_mmu.sv
verilog/cpu_core.sv
verilog/cpu_top.sv
verification/cpu_tb.sv

/* Makefile */
# Verilator build and run for the paged CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
